//--- common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int ROB_DEPTH  = 8;
    localparam int ROB_TAG_W  = 3;
    localparam int ROB_CNT_W  = 4;  // Counts 0 up to ROB_DEPTH.
    localparam int IQ_DEPTH   = 4;
    localparam int IQ_PTR_W   = 2;
    localparam int IQ_CNT_W   = 3;

    // Major opcodes in instruction bits 6:0.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // The decoder derives operand usage from ranges of this list, so the
    // order of the groups matters.
    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } rvOpE;

endpackage

`default_nettype wire

//--- src/instQueue.sv
`default_nettype none

module instQueue (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rdy,
    input  wire                      pushEn,
    input  wire  [cpuPkg::XLEN-1:0]  pushInst,
    input  wire  [cpuPkg::XLEN-1:0]  pushPc,
    input  wire                      pushPd,
    input  wire                      popEn,
    output logic                     full,
    output logic                     qValid,
    output logic [cpuPkg::XLEN-1:0]  qInst,
    output logic [cpuPkg::XLEN-1:0]  qPc,
    output logic                     qPd
);
    import cpuPkg::*;

    logic [XLEN-1:0]     instMem [IQ_DEPTH];
    logic [XLEN-1:0]     pcMem   [IQ_DEPTH];
    logic                pdMem   [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] wrPtr;
    logic [IQ_PTR_W-1:0] rdPtr;
    logic [IQ_CNT_W-1:0] count;
    logic                doPush;
    logic                doPop;

    assign full   = (count == IQ_CNT_W'(IQ_DEPTH));
    assign qValid = (count != '0);
    assign doPush = rdy && pushEn && !full;
    assign doPop  = rdy && popEn && qValid;

    // The head entry comes straight out of the storage registers.
    assign qInst = instMem[rdPtr];
    assign qPc   = pcMem[rdPtr];
    assign qPd   = pdMem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            instMem[wrPtr] <= pushInst;
            pcMem[wrPtr]   <= pushPc;
            pdMem[wrPtr]   <= pushPd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;  // Depth is a power of two, so it wraps.
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- decode/decoder.sv
`default_nettype none

module decoder (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rdy,
    input  wire                            qValid,
    input  wire  [cpuPkg::XLEN-1:0]        qInst,
    input  wire  [cpuPkg::XLEN-1:0]        qPc,
    input  wire                            qPd,
    input  wire                            robFree,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   allocTag,
    input  wire                            rs1Busy,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   rs1Tag,
    input  wire  [cpuPkg::XLEN-1:0]        rs1Value,
    input  wire                            rs2Busy,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   rs2Tag,
    input  wire  [cpuPkg::XLEN-1:0]        rs2Value,
    input  wire                            dispReady,
    output logic                           qPop,
    output logic                           allocEn,
    output logic [cpuPkg::REG_ADDR_W-1:0]  allocRd,
    output logic [cpuPkg::REG_ADDR_W-1:0]  rs1Name,
    output logic [cpuPkg::REG_ADDR_W-1:0]  rs2Name,
    output logic                           renEn,
    output logic [cpuPkg::REG_ADDR_W-1:0]  renRd,
    output logic [cpuPkg::ROB_TAG_W-1:0]   renTag,
    output logic                           dispValid,
    output cpuPkg::rvOpE                   dispOp,
    output logic [cpuPkg::XLEN-1:0]        dispPc,
    output logic [cpuPkg::XLEN-1:0]        dispImm,
    output logic                           dispPd,
    output logic [cpuPkg::REG_ADDR_W-1:0]  dispRd,
    output logic [cpuPkg::ROB_TAG_W-1:0]   dispTag,
    output logic                           src1Ready,
    output logic [cpuPkg::XLEN-1:0]        src1Value,
    output logic [cpuPkg::ROB_TAG_W-1:0]   src1Tag,
    output logic                           src2Ready,
    output logic [cpuPkg::XLEN-1:0]        src2Value,
    output logic [cpuPkg::ROB_TAG_W-1:0]   src2Tag
);
    import cpuPkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rdField;
    rvOpE                  op;
    logic [XLEN-1:0]       imm;
    logic                  isBranch;
    logic                  isStore;
    logic                  useRs1;
    logic                  useRs2;
    logic                  writesRd;
    logic                  accept;

    assign opcode  = qInst[6:0];
    assign funct3  = qInst[14:12];
    assign rdField = qInst[11:7];

    always_comb begin
        op = OP_NOP;
        case (opcode)
            OPC_LUI:    op = OP_LUI;
            OPC_AUIPC:  op = OP_AUIPC;
            OPC_JAL:    op = OP_JAL;
            OPC_JALR:   op = OP_JALR;
            OPC_BRANCH: case (funct3)
                3'b000:  op = OP_BEQ;
                3'b001:  op = OP_BNE;
                3'b100:  op = OP_BLT;
                3'b101:  op = OP_BGE;
                3'b110:  op = OP_BLTU;
                3'b111:  op = OP_BGEU;
                default: op = OP_NOP;
            endcase
            OPC_LOAD: case (funct3)
                3'b000:  op = OP_LB;
                3'b001:  op = OP_LH;
                3'b010:  op = OP_LW;
                3'b100:  op = OP_LBU;
                3'b101:  op = OP_LHU;
                default: op = OP_NOP;
            endcase
            OPC_STORE: case (funct3)
                3'b000:  op = OP_SB;
                3'b001:  op = OP_SH;
                3'b010:  op = OP_SW;
                default: op = OP_NOP;
            endcase
            OPC_OPIMM: case (funct3)
                3'b000:  op = OP_ADDI;
                3'b010:  op = OP_SLTI;
                3'b011:  op = OP_SLTIU;
                3'b100:  op = OP_XORI;
                3'b110:  op = OP_ORI;
                3'b111:  op = OP_ANDI;
                3'b001:  op = qInst[30] ? OP_NOP : OP_SLLI;  // No arithmetic left shift.
                default: op = qInst[30] ? OP_SRAI : OP_SRLI;
            endcase
            OPC_OP: case ({qInst[30], funct3})
                4'b0000: op = OP_ADD;
                4'b1000: op = OP_SUB;
                4'b0001: op = OP_SLL;
                4'b0010: op = OP_SLT;
                4'b0011: op = OP_SLTU;
                4'b0100: op = OP_XOR;
                4'b0101: op = OP_SRL;
                4'b1101: op = OP_SRA;
                4'b0110: op = OP_OR;
                4'b0111: op = OP_AND;
                default: op = OP_NOP;
            endcase
            default: op = OP_NOP;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_LUI, OPC_AUIPC: imm = {qInst[31:12], 12'b0};
            OPC_JAL:    imm = {{12{qInst[31]}}, qInst[19:12], qInst[20], qInst[30:21], 1'b0};
            OPC_BRANCH: imm = {{20{qInst[31]}}, qInst[7], qInst[30:25], qInst[11:8], 1'b0};
            OPC_JALR, OPC_LOAD, OPC_OPIMM: imm = {{21{qInst[31]}}, qInst[30:20]};
            OPC_STORE:  imm = {{21{qInst[31]}}, qInst[30:25], qInst[11:7]};
            default:    imm = '0;
        endcase
        if (op == OP_NOP) begin
            imm = '0;  // Illegal encodings carry no immediate.
        end
    end

    // Everything from JALR onwards reads rs1.
    assign isBranch = (op >= OP_BEQ) && (op <= OP_BGEU);
    assign isStore  = (op >= OP_SB) && (op <= OP_SW);
    assign useRs1   = (op >= OP_JALR);
    assign useRs2   = isBranch || isStore || (op >= OP_ADD);
    assign writesRd = (op != OP_NOP) && !isBranch && !isStore;

    // Take the queue head when the stage is empty or is handing off this cycle.
    assign accept  = rdy && qValid && robFree && (!dispValid || dispReady);
    assign qPop    = accept;
    assign allocEn = accept;
    assign allocRd = writesRd ? rdField : '0;
    assign renEn   = accept && writesRd && (rdField != '0);
    assign renRd   = rdField;
    assign renTag  = allocTag;
    assign rs1Name = useRs1 ? qInst[19:15] : '0;  // Unused sources look up x0.
    assign rs2Name = useRs2 ? qInst[24:20] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            dispValid <= 1'b0;
        end else if (accept) begin
            dispValid <= 1'b1;
        end else if (rdy && dispReady) begin
            dispValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dispOp    <= op;
            dispPc    <= qPc;
            dispImm   <= imm;
            dispPd    <= qPd;
            dispRd    <= allocRd;
            dispTag   <= allocTag;
            src1Ready <= !rs1Busy;
            src1Value <= rs1Value;
            src1Tag   <= rs1Tag;
            src2Ready <= !rs2Busy;
            src2Value <= rs2Value;
            src2Tag   <= rs2Tag;
        end
    end

endmodule

`default_nettype wire

//--- rename/regFile.sv
`default_nettype none

module regFile (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rdy,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]  rs1Name,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]  rs2Name,
    input  wire                            renEn,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]  renRd,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   renTag,
    input  wire                            commitValid,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]  commitRd,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   commitTag,
    input  wire  [cpuPkg::XLEN-1:0]        commitValue,
    output logic                           rs1Busy,
    output logic [cpuPkg::ROB_TAG_W-1:0]   rs1Tag,
    output logic [cpuPkg::XLEN-1:0]        rs1Value,
    output logic                           rs2Busy,
    output logic [cpuPkg::ROB_TAG_W-1:0]   rs2Tag,
    output logic [cpuPkg::XLEN-1:0]        rs2Value
);
    import cpuPkg::*;

    logic [XLEN-1:0]      regQ [NUM_REGS];
    logic [ROB_TAG_W-1:0] tagQ [NUM_REGS];
    logic [NUM_REGS-1:0]  busyQ;
    logic                 commitHit;

    // Only the youngest producer of a register may release it.
    assign commitHit = rdy && commitValid && (commitRd != '0) &&
                       busyQ[commitRd] && (tagQ[commitRd] == commitTag);

    // Lookups see the state as it stands after this cycle's commit.
    always_comb begin
        rs1Busy  = busyQ[rs1Name];
        rs1Tag   = tagQ[rs1Name];
        rs1Value = regQ[rs1Name];
        if (commitHit && (commitRd == rs1Name)) begin
            rs1Busy  = 1'b0;
            rs1Value = commitValue;
        end
        rs2Busy  = busyQ[rs2Name];
        rs2Tag   = tagQ[rs2Name];
        rs2Value = regQ[rs2Name];
        if (commitHit && (commitRd == rs2Name)) begin
            rs2Busy  = 1'b0;
            rs2Value = commitValue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busyQ <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regQ[i] <= '0;
                tagQ[i] <= '0;
            end
        end else begin
            if (commitHit) begin
                regQ[commitRd]  <= commitValue;
                busyQ[commitRd] <= 1'b0;
            end
            if (rdy && renEn && (renRd != '0)) begin
                busyQ[renRd] <= 1'b1;  // Wins over a commit to the same register.
                tagQ[renRd]  <= renTag;
            end
        end
    end

endmodule

`default_nettype wire

//--- rename/reorderBuffer.sv
`default_nettype none

module reorderBuffer (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rdy,
    input  wire                            allocEn,
    input  wire  [cpuPkg::REG_ADDR_W-1:0]  allocRd,
    input  wire                            wbValid,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   wbTag,
    input  wire  [cpuPkg::XLEN-1:0]        wbValue,
    output logic                           robFree,
    output logic [cpuPkg::ROB_TAG_W-1:0]   allocTag,
    output logic                           commitValid,
    output logic [cpuPkg::REG_ADDR_W-1:0]  commitRd,
    output logic [cpuPkg::ROB_TAG_W-1:0]   commitTag,
    output logic [cpuPkg::XLEN-1:0]        commitValue
);
    import cpuPkg::*;

    logic [ROB_DEPTH-1:0]  entValid;
    logic [ROB_DEPTH-1:0]  entDone;
    logic [REG_ADDR_W-1:0] entRd    [ROB_DEPTH];
    logic [XLEN-1:0]       entValue [ROB_DEPTH];
    logic [ROB_TAG_W-1:0]  head;
    logic [ROB_TAG_W-1:0]  tail;
    logic [ROB_CNT_W-1:0]  count;
    logic                  doAlloc;
    logic                  doCommit;

    assign robFree  = (count != ROB_CNT_W'(ROB_DEPTH));
    assign allocTag = tail;
    assign doAlloc  = rdy && allocEn && robFree;
    assign doCommit = rdy && entValid[head] && entDone[head];

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            entRd[tail] <= allocRd;
        end
        if (rdy && wbValid) begin
            entValue[wbTag] <= wbValue;
        end
        if (doCommit) begin
            commitRd    <= entRd[head];
            commitTag   <= head;
            commitValue <= entValue[head];
        end
    end

    // The commit pulse is held through a stall and takes effect once rdy is high.
    always_ff @(posedge clk) begin
        if (rst) begin
            entValid    <= '0;
            entDone     <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            commitValid <= 1'b0;
        end else if (rdy) begin
            commitValid <= doCommit;
            if (doAlloc) begin
                entValid[tail] <= 1'b1;
                entDone[tail]  <= 1'b0;
                tail           <= tail + 1'b1;
            end
            if (wbValid) begin
                entDone[wbTag] <= 1'b1;
            end
            if (doCommit) begin
                entValid[head] <= 1'b0;
                head           <= head + 1'b1;
            end
            case ({doAlloc, doCommit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/dispatchTop.sv
`default_nettype none

module dispatchTop (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            rdy,
    input  wire                            fetchValid,
    input  wire  [cpuPkg::XLEN-1:0]        fetchInst,
    input  wire  [cpuPkg::XLEN-1:0]        fetchPc,
    input  wire                            fetchPd,
    output logic                           fetchReady,
    output logic                           dispValid,
    output cpuPkg::rvOpE                   dispOp,
    output logic [cpuPkg::XLEN-1:0]        dispPc,
    output logic [cpuPkg::XLEN-1:0]        dispImm,
    output logic                           dispPd,
    output logic [cpuPkg::REG_ADDR_W-1:0]  dispRd,
    output logic [cpuPkg::ROB_TAG_W-1:0]   dispTag,
    output logic                           src1Ready,
    output logic [cpuPkg::XLEN-1:0]        src1Value,
    output logic [cpuPkg::ROB_TAG_W-1:0]   src1Tag,
    output logic                           src2Ready,
    output logic [cpuPkg::XLEN-1:0]        src2Value,
    output logic [cpuPkg::ROB_TAG_W-1:0]   src2Tag,
    input  wire                            dispReady,
    input  wire                            wbValid,
    input  wire  [cpuPkg::ROB_TAG_W-1:0]   wbTag,
    input  wire  [cpuPkg::XLEN-1:0]        wbValue,
    output logic                           commitValid,
    output logic [cpuPkg::REG_ADDR_W-1:0]  commitRd,
    output logic [cpuPkg::ROB_TAG_W-1:0]   commitTag,
    output logic [cpuPkg::XLEN-1:0]        commitValue
);
    import cpuPkg::*;

    logic                  full, qValid, qPd, qPop, allocEn, robFree;
    logic                  renEn, rs1Busy, rs2Busy;
    logic [XLEN-1:0]       qInst, qPc, rs1Value, rs2Value;
    logic [REG_ADDR_W-1:0] allocRd, rs1Name, rs2Name, renRd;
    logic [ROB_TAG_W-1:0]  allocTag, renTag, rs1Tag, rs2Tag;

    assign fetchReady = !full;

    instQueue instQueue_i (
        .pushEn   (fetchValid),
        .pushInst (fetchInst),
        .pushPc   (fetchPc),
        .pushPd   (fetchPd),
        .popEn    (qPop),
        .*
    );

    decoder decoder_i (.*);

    regFile regFile_i (.*);

    reorderBuffer reorderBuffer_i (.*);

endmodule

`default_nettype wire

//--- tests/tbDispatch.sv
`default_nettype none

module tbDispatch;
    timeunit 1ns;
    timeprecision 1ps;
    import cpuPkg::*;

    localparam int NUM_INST = 300;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  rdy = 1'b1;
    logic                  fetchValid = 1'b0;
    logic [XLEN-1:0]       fetchInst = '0;
    logic [XLEN-1:0]       fetchPc = 32'h0000_1000;
    logic                  fetchPd = 1'b0;
    logic                  dispReady = 1'b0;
    logic                  wbValid = 1'b0;
    logic [ROB_TAG_W-1:0]  wbTag = '0;
    logic [XLEN-1:0]       wbValue = '0;
    logic                  fetchReady, dispValid, dispPd, src1Ready, src2Ready, commitValid;
    rvOpE                  dispOp;
    logic [XLEN-1:0]       dispPc, dispImm, src1Value, src2Value, commitValue;
    logic [REG_ADDR_W-1:0] dispRd, commitRd;
    logic [ROB_TAG_W-1:0]  dispTag, src1Tag, src2Tag, commitTag;

    // Model state. Shadow registers follow the DUT's rename and commit order.
    integer                seed = 38977;
    logic [XLEN-1:0]       instQ [$];
    logic [XLEN-1:0]       pcQ [$];
    logic                  pdQ [$];
    logic [ROB_TAG_W-1:0]  robTagQ [$];
    logic [REG_ADDR_W-1:0] robRdQ [$];
    logic [ROB_TAG_W-1:0]  wbPendQ [$];
    logic [XLEN-1:0]       wbVal [ROB_DEPTH];
    logic [XLEN-1:0]       shReg [NUM_REGS];
    logic [ROB_TAG_W-1:0]  shTag [NUM_REGS];
    logic [NUM_REGS-1:0]   shBusy = '0;
    int                    pushCnt = 0;
    int                    dispCnt = 0;
    int                    commitCnt = 0;
    int                    errors = 0;

    rvOpE branchOps [8] = '{OP_BEQ, OP_BNE, OP_NOP, OP_NOP, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    rvOpE loadOps   [8] = '{OP_LB, OP_LH, OP_LW, OP_NOP, OP_LBU, OP_LHU, OP_NOP, OP_NOP};
    rvOpE storeOps  [8] = '{OP_SB, OP_SH, OP_SW, OP_NOP, OP_NOP, OP_NOP, OP_NOP, OP_NOP};
    rvOpE immOps    [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
    rvOpE regOps   [16] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND,
                            OP_SUB, OP_NOP, OP_NOP, OP_NOP, OP_NOP, OP_SRA, OP_NOP, OP_NOP};

    dispatchTop dut_i (.*);

    always #2 clk = ~clk;

    task automatic reportError(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic decodeModel(input logic [XLEN-1:0] inst, output rvOpE op,
                               output logic [XLEN-1:0] imm, output logic [REG_ADDR_W-1:0] rd,
                               output logic [REG_ADDR_W-1:0] s1,
                               output logic [REG_ADDR_W-1:0] s2);
        logic [2:0] f3;
        logic       hasRd;
        logic       hasS1;
        logic       hasS2;
        f3 = inst[14:12];
        op = OP_NOP;
        imm = {{20{inst[31]}}, inst[31:20]};  // I format unless changed below.
        hasRd = 1'b1;
        hasS1 = 1'b1;
        hasS2 = 1'b0;
        case (inst[6:0])
            OPC_LUI, OPC_AUIPC: begin
                op = (inst[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
                imm = {inst[31:12], 12'h000};
                hasS1 = 1'b0;
            end
            OPC_JAL: begin
                op = OP_JAL;
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
                hasS1 = 1'b0;
            end
            OPC_JALR: op = OP_JALR;
            OPC_BRANCH: begin
                op = branchOps[f3];
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                hasRd = 1'b0;
                hasS2 = 1'b1;
            end
            OPC_LOAD: op = loadOps[f3];
            OPC_STORE: begin
                op = storeOps[f3];
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
                hasRd = 1'b0;
                hasS2 = 1'b1;
            end
            OPC_OPIMM: begin
                op = immOps[f3];
                if (f3 == 3'd1 && inst[30]) op = OP_NOP;
                if (f3 == 3'd5 && inst[30]) op = OP_SRAI;
            end
            OPC_OP: begin
                op = regOps[{inst[30], f3}];
                imm = '0;  // R format carries no immediate.
                hasS2 = 1'b1;
            end
            default: op = OP_NOP;
        endcase
        if (op == OP_NOP) begin
            imm = '0;
            hasRd = 1'b0;
            hasS1 = 1'b0;
            hasS2 = 1'b0;
        end
        rd = hasRd ? inst[11:7] : '0;
        s1 = hasS1 ? inst[19:15] : '0;
        s2 = hasS2 ? inst[24:20] : '0;
    endtask

    function automatic logic [XLEN-1:0] randomInst();
        logic [6:0]      opcs [9];
        logic [XLEN-1:0] word;
        int              pick;
        opcs = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE,
                 OPC_OPIMM, OPC_OP};
        word = $random(seed);
        pick = {$random(seed)} % 11;
        if (pick < 9) word[6:0] = opcs[pick];  // Otherwise the opcode stays random.
        // Names stay in x0..x7 so that dependencies are frequent.
        word[11:10] = 2'b00;
        word[19:18] = 2'b00;
        word[24:23] = 2'b00;
        return word;
    endfunction

    task automatic checkSource(input int idx, input logic [REG_ADDR_W-1:0] name,
                               input logic ready, input logic [XLEN-1:0] value,
                               input logic [ROB_TAG_W-1:0] tag);
        if (shBusy[name]) begin
            if (ready !== 1'b0 || tag !== shTag[name])
                reportError($sformatf("src%0d x%0d should wait on tag %0d, got ready %b tag %0d",
                                      idx, name, shTag[name], ready, tag));
        end else if (ready !== 1'b1 || value !== shReg[name]) begin
            reportError($sformatf("src%0d x%0d should be ready with %h, got ready %b value %h",
                                  idx, name, shReg[name], ready, value));
        end
    endtask

    task automatic checkPacket();
        rvOpE                  op;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       pc;
        logic                  pd;
        logic [REG_ADDR_W-1:0] rd, s1, s2;
        logic [ROB_TAG_W-1:0]  tag;
        if (instQ.size() == 0) begin
            errors++;
            $display("A packet was dispatched that was never fetched");
        end else begin
            decodeModel(instQ.pop_front(), op, imm, rd, s1, s2);
            pc = pcQ.pop_front();
            pd = pdQ.pop_front();
            tag = ROB_TAG_W'(dispCnt);  // Tags are handed out in order, modulo ROB_DEPTH.
            if (dispOp !== op)
                reportError($sformatf("dispOp %s, expected %s", dispOp.name(), op.name()));
            if (dispImm !== imm)
                reportError($sformatf("dispImm %h, expected %h", dispImm, imm));
            if (dispPc !== pc || dispPd !== pd)
                reportError($sformatf("dispPc/Pd %h/%b, expected %h/%b", dispPc, dispPd, pc, pd));
            if (dispRd !== rd || dispTag !== tag)
                reportError($sformatf("dispRd/Tag %0d/%0d, expected %0d/%0d",
                                      dispRd, dispTag, rd, tag));
            checkSource(1, s1, src1Ready, src1Value, src1Tag);
            checkSource(2, s2, src2Ready, src2Value, src2Tag);
            if (rd != '0) begin
                shBusy[rd] = 1'b1;
                shTag[rd] = tag;
            end
            robTagQ.push_back(tag);
            robRdQ.push_back(rd);
            wbPendQ.push_back(tag);
            if (robTagQ.size() > ROB_DEPTH) begin
                errors++;
                $display("More than %0d instructions are in flight", ROB_DEPTH);
            end
            dispCnt++;
        end
    endtask

    task automatic checkCommit();
        logic [ROB_TAG_W-1:0]  tag;
        logic [REG_ADDR_W-1:0] rd;
        if (robTagQ.size() == 0) begin
            errors++;
            $display("A commit arrived with no instruction in flight");
        end else begin
            tag = robTagQ.pop_front();
            rd = robRdQ.pop_front();
            if (commitTag !== tag || commitRd !== rd || commitValue !== wbVal[tag])
                reportError($sformatf("commit tag/rd/value %0d/%0d/%h, expected %0d/%0d/%h",
                                      commitTag, commitRd, commitValue, tag, rd, wbVal[tag]));
            if (rd != '0 && shBusy[rd] && shTag[rd] == tag) begin
                shReg[rd] = wbVal[tag];
                shBusy[rd] = 1'b0;
            end
            commitCnt++;
        end
    endtask

    initial begin
        int   cycle;
        int   idx;
        int   testErrors;
        logic fetchTaken;
        logic prevValid;
        logic prevXfer;
        logic sawFull;
        cycle = 0;
        fetchTaken = 1'b0;
        prevValid = 1'b0;
        prevXfer = 1'b0;
        sawFull = 1'b0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shReg[i] = '0;
            shTag[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (8) begin
            @(negedge clk);
            if (dispValid !== 1'b0 || commitValid !== 1'b0 || fetchReady !== 1'b1)
                reportError("outputs are not idle after reset");
        end
        $display("Test 1 (idle after reset) finished with %0d errors", errors);

        testErrors = errors;
        while (commitCnt < NUM_INST) begin
            @(negedge clk);
            cycle++;
            if (fetchTaken) begin
                fetchValid = 1'b0;
                fetchPc = fetchPc + 4;
                fetchTaken = 1'b0;
            end
            // A new packet appears when the stage was empty or just handed off.
            if (dispValid && (!prevValid || prevXfer)) checkPacket();
            if (!fetchReady) sawFull = 1'b1;
            rdy = ($random(seed) % 16) != 0;
            dispReady = (cycle % 64 >= 16) && (($random(seed) & 3) != 0);
            if (commitValid && rdy) checkCommit();
            prevValid = dispValid;
            prevXfer = dispValid && dispReady && rdy;
            if (!fetchValid && pushCnt < NUM_INST && ($random(seed) & 3) != 0) begin
                fetchValid = 1'b1;
                fetchInst = randomInst();
                fetchPd = ($random(seed) & 1) != 0;
            end
            if (fetchValid && fetchReady && rdy) begin
                instQ.push_back(fetchInst);
                pcQ.push_back(fetchPc);
                pdQ.push_back(fetchPd);
                pushCnt++;
                fetchTaken = 1'b1;
            end
            wbValid = 1'b0;
            if (rdy && wbPendQ.size() != 0 && ($random(seed) & 3) != 0) begin
                idx = {$random(seed)} % wbPendQ.size();  // Results return out of order.
                wbTag = wbPendQ[idx];
                wbPendQ.delete(idx);
                wbValue = $random(seed);
                wbVal[wbTag] = wbValue;
                wbValid = 1'b1;
            end
        end
        if (!sawFull) begin
            errors++;
            $display("The instruction queue never filled, fetchReady was never low");
        end
        $display("Test 2 (random traffic) finished: %0d dispatched, %0d committed, %0d errors",
                 dispCnt, commitCnt, errors - testErrors);

        testErrors = errors;
        rdy = 1'b1;
        dispReady = 1'b1;
        wbValid = 1'b0;
        fetchValid = 1'b0;
        repeat (2) @(negedge clk);
        repeat (6) begin
            @(negedge clk);
            if (dispValid !== 1'b0 || commitValid !== 1'b0 || fetchReady !== 1'b1)
                reportError("outputs are not idle after the drain");
        end
        if (instQ.size() != 0 || robTagQ.size() != 0 || pushCnt != dispCnt || shBusy != '0) begin
            errors++;
            $display("Instructions were left in flight after the drain");
        end
        $display("Test 3 (drain) finished with %0d errors", errors - testErrors);

        $display("Totals: %0d fetched, %0d dispatched, %0d committed, %0d errors",
                 pushCnt, dispCnt, commitCnt, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (NUM_INST * 200) @(posedge clk);
        $display("Watchdog expired with %0d of %0d instructions committed", commitCnt, NUM_INST);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
common/cpuPkg.sv
src/instQueue.sv
decode/decoder.sv
rename/regFile.sv
rename/reorderBuffer.sv
src/dispatchTop.sv
tests/tbDispatch.sv

//--- Bender.yml
package:
  name: dispatch_front_end

sources:
  - common/cpuPkg.sv
  - src/instQueue.sv
  - decode/decoder.sv
  - rename/regFile.sv
  - rename/reorderBuffer.sv
  - src/dispatchTop.sv
  - target: test
    files:
      - tests/tbDispatch.sv
